/* dv/geometry_cases.txt */
// geometry test cases as 32-bit hex words. first word: number of cases. per case: tri_count,
// stall mode (0 none, 1 random gaps, 2 long holds), 16 matrix entries row-major in 16.16,
// then for each vertex x y z rgb, with the colour in bits 23:0 of the rgb word.
00000003
// case 0: identity matrix, one triangle, no stall.
00000001 00000000
00010000 00000000 00000000 00000000
00000000 00010000 00000000 00000000
00000000 00000000 00010000 00000000
00000000 00000000 00000000 00010000
00008000 FFFFC000 0000C000 AB123456
FFFF0000 00010000 00000000 00FF0000
00002000 FFFF8000 FFFFFFFF 7F00FF00
// case 1: negative and fractional entries, three triangles, random stall gaps.
00000003 00000001
0000C000 FFFF8000 00002000 00001000
00004000 00011000 FFFFE000 FFFFF000
FFFF0000 00000000 00008000 00000800
00000100 FFFFFF00 00000010 00010000
00003333 FFFF9999 00001111 00102030
FFFEC000 00024000 FFFFF123 00405060
0000ABCD 00000001 FFFF0001 80708090
00007FFF FFFF8001 00010001 00A0B0C0
FFFFFFF0 00000010 00C00000 C0D0E0F0
00020000 FFFE0000 00000000 00010203
FFFF4000 0000C000 FFFFC000 00040506
00001000 FFFFF000 00040000 00070809
00035555 FFFCAAAB 00000003 000A0B0C
// case 2: rotation about z with a depth flip, two triangles, long stall holds.
00000002 00000002
0000B505 FFFF4AFB 00000000 00000000
0000B505 0000B505 00000000 00000000
00000000 00000000 FFFF0000 00008000
00000000 00000000 00000000 00010000
00010000 00000000 00008000 11223344
00000000 00010000 FFFF8000 55667788
FFFF0000 FFFF0000 00000000 99AABBCC
00004000 00004000 00004000 00DDEEFF
FFFFC000 00004000 FFFFC000 00123123
00000000 FFFF0000 00010000 FF456456

/* dv/geometry_checker.sv */
// Monitor that predicts the geometry front end's screen output from the cases file and compares it.
`default_nettype none

module geometry_checker (
    input  logic        clock,
    input  logic        reset,
    input  logic        host_we,
    input  logic [7:0]  host_addr,
    input  logic [31:0] host_wdata,
    input  logic        host_ack,
    input  logic [31:0] host_rdata,
    input  logic        busy,
    input  logic [31:0] x_out [3],
    input  logic [31:0] y_out [3],
    input  logic [31:0] z_out [3],
    input  logic [31:0] w_out [3],
    input  logic [23:0] color_out [3],
    input  logic        out_valid,
    input  logic        out_stall,
    output int          error_count,
    output int          check_count,
    output int          cases_done
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] case_words [1024];
    int          case_ptr [8];
    int          n_cases;
    int          result_idx;  // results seen in the running case.
    int          case_errors;
    logic        reset_checked;
    logic        busy_q;
    logic        ack_q;
    logic        held;
    logic [31:0] hold_x [3];
    logic [31:0] hold_y [3];
    logic [31:0] hold_z [3];
    logic [31:0] hold_w [3];
    logic [23:0] hold_color [3];
    logic [31:0] shadow [256]; // what the host last wrote.
    logic        written [256];

    // 64-bit signed product, bits 47:16 are the 16.16 result.
    function automatic logic [31:0] fixed_mul(input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] p;
        p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        return p[47:16];
    endfunction

    function automatic int vertex_word(input int c, input int t, input int v);
        return case_ptr[c] + 18 + 12 * t + 4 * v;
    endfunction

    // r selects x, y, z or w.
    function automatic logic [31:0] screen_coord(input int c, input int t, input int v, input int r);
        int m;
        int p;
        logic [31:0] sum;
        logic [31:0] scale;
        m = case_ptr[c] + 2 + 4 * r;
        p = vertex_word(c, t, v);
        sum = fixed_mul(case_words[m], case_words[p]) + fixed_mul(case_words[m + 1], case_words[p + 1])
            + fixed_mul(case_words[m + 2], case_words[p + 2]) + case_words[m + 3];
        scale = (r == 0 || r == 2) ? 32'h0140_0000 : 32'h00F0_0000; // 320.0 or 240.0.
        return fixed_mul(sum, scale) + scale;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
            case_errors++;
        end
    endtask

    task automatic check_vertex(input int v, input logic [31:0] ex, input logic [31:0] ey,
                                input logic [31:0] ez, input logic [31:0] ew, input logic [23:0] ec);
        check_value($sformatf("x_out[%0d]", v), ex, x_out[v]);
        check_value($sformatf("y_out[%0d]", v), ey, y_out[v]);
        check_value($sformatf("z_out[%0d]", v), ez, z_out[v]);
        check_value($sformatf("w_out[%0d]", v), ew, w_out[v]);
        check_value($sformatf("color_out[%0d]", v), 32'(ec), 32'(color_out[v]));
    endtask

    initial begin
        int ptr;
        error_count = 0;
        check_count = 0;
        cases_done = 0;
        result_idx = 0;
        case_errors = 0;
        reset_checked = 1'b0;
        busy_q = 1'b0;
        ack_q = 1'b0;
        held = 1'b0;
        for (int i = 0; i < 256; i++) begin
            written[i] = 1'b0;
        end
        $readmemh("dv/geometry_cases.txt", case_words);
        n_cases = int'(case_words[0]);
        ptr = 1;
        for (int c = 0; c < n_cases; c++) begin
            case_ptr[c] = ptr;
            ptr += 18 + 12 * int'(case_words[ptr]);
        end
    end

    always @(posedge clock) begin
        int tri_n;
        tri_n = (cases_done < n_cases) ? int'(case_words[case_ptr[cases_done]]) : 0;
        if (reset && !reset_checked) begin // first edge out of reset.
            check_value("out_valid", 32'd0, 32'(out_valid));
            check_value("busy", 32'd0, 32'(busy));
            check_value("host_ack", 32'd0, 32'(host_ack));
            reset_checked = 1'b1;
        end
        if (reset) begin
            if (host_ack && !ack_q) begin
                if (host_we) begin
                    shadow[host_addr] = host_wdata;
                    written[host_addr] = 1'b1;
                end else if (!written[host_addr]) begin
                    $display("host read address %0d before writing it", host_addr);
                    error_count++;
                end else begin
                    check_value("host_rdata", shadow[host_addr], host_rdata);
                end
            end
            if (held) begin // stalled last edge, so nothing may move.
                check_value("out_valid", 32'd1, 32'(out_valid));
                for (int v = 0; v < 3; v++) begin
                    check_vertex(v, hold_x[v], hold_y[v], hold_z[v], hold_w[v], hold_color[v]);
                end
            end
            held = out_valid && out_stall;
            for (int v = 0; v < 3; v++) begin
                hold_x[v] = x_out[v];
                hold_y[v] = y_out[v];
                hold_z[v] = z_out[v];
                hold_w[v] = w_out[v];
                hold_color[v] = color_out[v];
            end
            if (out_valid && !out_stall) begin
                if (result_idx >= tri_n) begin
                    $display("result at %0t arrived with no triangle left in the batch", $time);
                    error_count++;
                    case_errors++;
                end else begin
                    for (int v = 0; v < 3; v++) begin
                        check_vertex(v, screen_coord(cases_done, result_idx, v, 0),
                                     screen_coord(cases_done, result_idx, v, 1),
                                     screen_coord(cases_done, result_idx, v, 2),
                                     screen_coord(cases_done, result_idx, v, 3),
                                     case_words[vertex_word(cases_done, result_idx, v) + 3][23:0]);
                    end
                    result_idx++;
                end
            end
            if (busy_q && !busy) begin
                if (result_idx != tri_n) begin
                    $display("case %0d: busy fell after %0d results, %0d expected", cases_done,
                             result_idx, tri_n);
                    error_count++;
                    case_errors++;
                end
                $display("case %0d finished: %0d triangles, %0d errors", cases_done, result_idx,
                         case_errors);
                cases_done++;
                result_idx = 0;
                case_errors = 0;
            end
        end
        busy_q = busy;
        ack_q = host_ack;
    end

endmodule

`default_nettype wire

/* dv/geometry_tb.sv */
// Testbench top for the geometry front end: runs every case of the cases file through the DUT.
`default_nettype none

module geometry_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_WORDS = 1024;
    localparam int MAX_CASES = 8;

    logic        clock;
    logic        reset;
    logic        host_req;
    logic        host_we;
    logic [7:0]  host_addr;
    logic [31:0] host_wdata;
    logic        host_ack;
    logic [31:0] host_rdata;
    logic        mat_we;
    logic [3:0]  mat_index;
    logic [31:0] mat_data;
    logic        start;
    logic [7:0]  tri_base;
    logic [4:0]  tri_count;
    logic        busy;
    logic [31:0] x_out [3];
    logic [31:0] y_out [3];
    logic [31:0] z_out [3];
    logic [31:0] w_out [3];
    logic [23:0] color_out [3];
    logic        out_valid;
    logic        out_stall;

    logic [31:0] case_words [MAX_WORDS];
    int          case_ptr [MAX_CASES]; // index of each case's tri_count word.
    int          n_cases;
    int          stall_mode;           // 0 none, 1 random gaps, 2 long holds.
    int          stall_left;
    int          cycles;
    int          cycle_limit;
    int          error_count;
    int          check_count;
    int          cases_done;

    geometry_top geometry_top_inst (.*);

    geometry_checker checker_inst (.*);

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles, limit %0d", cycles, cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // downstream back-pressure.
    always @(posedge clock) begin
        if (stall_mode == 1) begin
            out_stall <= ($urandom % 3) == 0;
        end else if (stall_mode == 2) begin
            if (stall_left == 0) begin
                out_stall <= !out_stall;
                // a hold outlasts a triangle fetch, so the next triangle meets a full stage.
                stall_left <= out_stall ? 1 + $urandom % 3 : 120 + $urandom % 40;
            end else begin
                stall_left <= stall_left - 1;
            end
        end else begin
            out_stall <= 1'b0;
        end
    end

    // one four-phase access, req held until ack and released before the next one.
    task automatic host_access(input logic we, input logic [7:0] addr, input logic [31:0] data);
        @(posedge clock);
        host_req <= 1'b1;
        host_we <= we;
        host_addr <= addr;
        host_wdata <= data;
        do @(posedge clock); while (!host_ack);
        host_req <= 1'b0;
        do @(posedge clock); while (host_ack);
    endtask

    // even cases live at word 0, odd cases at word 128.
    task automatic copy_triangles(input int c);
        int n;
        int base;
        n = 12 * int'(case_words[case_ptr[c]]);
        base = 128 * (c % 2);
        for (int i = 0; i < n; i++) begin
            host_access(1'b1, 8'(base + i), case_words[case_ptr[c] + 18 + i]);
        end
        for (int i = 0; i < n; i++) begin
            host_access(1'b0, 8'(base + i), 32'h0); // read back.
        end
    endtask

    task automatic load_matrix(input int c);
        for (int i = 0; i < 16; i++) begin
            @(posedge clock);
            mat_we <= 1'b1;
            mat_index <= 4'(i);
            mat_data <= case_words[case_ptr[c] + 2 + i];
        end
        @(posedge clock);
        mat_we <= 1'b0;
    endtask

    task automatic run_batch(input int c);
        @(posedge clock);
        stall_mode <= int'(case_words[case_ptr[c] + 1]);
        start <= 1'b1;
        tri_base <= 8'(128 * (c % 2));
        tri_count <= 5'(case_words[case_ptr[c]]);
        @(posedge clock);
        start <= 1'b0;
        do @(posedge clock); while (!busy);
        do @(posedge clock); while (busy);
        stall_mode <= 0;
    endtask

    initial begin
        int ptr;
        void'($urandom(32'h919dce3e));
        clock = 1'b0;
        reset = 1'b0;
        host_req = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        mat_we = 1'b0;
        mat_index = '0;
        mat_data = '0;
        start = 1'b0;
        tri_base = '0;
        tri_count = '0;
        out_stall = 1'b0;
        stall_mode = 0;
        stall_left = 0;
        cycles = 0;
        $readmemh("dv/geometry_cases.txt", case_words);
        n_cases = int'(case_words[0]);
        ptr = 1;
        cycle_limit = 500;
        for (int c = 0; c < n_cases; c++) begin
            case_ptr[c] = ptr;
            cycle_limit += (60 + 8 * 24) * int'(case_words[ptr]); // 24 host accesses per triangle.
            ptr += 18 + 12 * int'(case_words[ptr]);
        end
        repeat (5) @(posedge clock);
        reset <= 1'b1;
        copy_triangles(0);
        for (int c = 0; c < n_cases; c++) begin
            load_matrix(c);
            fork
                run_batch(c);
                begin
                    if (c + 1 < n_cases) begin
                        copy_triangles(c + 1); // next case goes in while this batch runs.
                    end
                end
            join
        end
        repeat (4) @(posedge clock);
        if (cases_done != n_cases) begin
            $display("only %0d of %0d batches reached their end", cases_done, n_cases);
        end
        $display("cases %0d of %0d, checks %0d, errors %0d", cases_done, n_cases, check_count,
                 error_count);
        if (error_count == 0 && cases_done == n_cases && check_count > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run from the project root, then judge the log.
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module geometry_tb -f vlog.f -o geometry_sim \
    && ./obj_dir/geometry_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0

/* source/geometry_top.sv */
// Geometry front end top level, wiring host ports, memory arbiter, fetch engine and transform stage.
`default_nettype none

module geometry_top
    import gfx_fixed_pkg::*;
    import gfx_mem_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       host_req,
    input  logic       host_we,
    input  mem_addr_t  host_addr,
    input  mem_word_t  host_wdata,
    output logic       host_ack,
    output mem_word_t  host_rdata,
    input  logic       mat_we,
    input  mat_index_t mat_index,
    input  fixed_t     mat_data,
    input  logic       start,
    input  mem_addr_t  tri_base,
    input  tri_count_t tri_count,
    output logic       busy,
    output fixed_t     x_out [3],
    output fixed_t     y_out [3],
    output fixed_t     z_out [3],
    output fixed_t     w_out [3],
    output color_t     color_out [3],
    output logic       out_valid,
    input  logic       out_stall
);

    fixed_t tri_vertex [9];
    color_t tri_color [3];
    logic   tri_valid;
    logic   tri_stall;

    vertex_mem_if host_bus ();
    vertex_mem_if fetch_bus ();

    // host side of the memory, straight from the pins.
    assign host_bus.req = host_req;
    assign host_bus.we = host_we;
    assign host_bus.addr = host_addr;
    assign host_bus.wdata = host_wdata;
    assign host_ack = host_bus.ack;
    assign host_rdata = host_bus.rdata;

    vertex_mem_arbiter vertex_mem_arbiter_inst (
        .clock (clock),
        .reset (reset),
        .host  (host_bus.arbiter),
        .fetch (fetch_bus.arbiter)
    );

    triangle_fetch triangle_fetch_inst (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .tri_base    (tri_base),
        .tri_count   (tri_count),
        .mem         (fetch_bus.requester),
        .tri_vertex  (tri_vertex),
        .tri_color   (tri_color),
        .tri_valid   (tri_valid),
        .tri_stall   (tri_stall),
        .stage_valid (out_valid),
        .busy        (busy)
    );

    vertex_transform vertex_transform_inst (
        .clock      (clock),
        .reset      (reset),
        .mat_we     (mat_we),
        .mat_index  (mat_index),
        .mat_data   (mat_data),
        .tri_vertex (tri_vertex),
        .tri_color  (tri_color),
        .tri_valid  (tri_valid),
        .tri_stall  (tri_stall),
        .x_out      (x_out),
        .y_out      (y_out),
        .z_out      (z_out),
        .w_out      (w_out),
        .color_out  (color_out),
        .out_valid  (out_valid),
        .out_stall  (out_stall)
    );

endmodule

`default_nettype wire

/* source/gfx_fixed_pkg.sv */
// 16.16 fixed-point types, the truncating multiply and the viewport constants, imported by RTL.
`default_nettype none

package gfx_fixed_pkg;

    typedef logic [31:0] fixed_t;     // signed 16.16.
    typedef logic [23:0] color_t;     // packed rgb.
    typedef logic [3:0]  mat_index_t; // row-major matrix entry.

    localparam int FRAC_BITS = 16;

    // viewport scale and offset.
    localparam fixed_t HALF_WIDTH  = fixed_t'(320 << FRAC_BITS);
    localparam fixed_t HALF_HEIGHT = fixed_t'(240 << FRAC_BITS);

    // full 64-bit signed product, truncated back to 16.16.
    function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
        logic signed [63:0] wide_a;
        logic signed [63:0] wide_b;
        logic signed [63:0] prod;
        wide_a = 64'($signed(a));
        wide_b = 64'($signed(b));
        prod = wide_a * wide_b;
        return fixed_t'(prod >>> FRAC_BITS);
    endfunction

endpackage

`default_nettype wire

/* source/gfx_mem_pkg.sv */
// Vertex memory map types and sizes, imported by the memory bus, the arbiter and the fetch engine.
`default_nettype none

package gfx_mem_pkg;

    typedef logic [7:0]  mem_addr_t;  // word address.
    typedef logic [31:0] mem_word_t;
    typedef logic [4:0]  tri_count_t; // triangles per batch.

    localparam int MEM_DEPTH = 256;

    // x, y, z, rgb for each of the three vertices.
    // rgb sits in bits 23:0 of its word.
    localparam int WORDS_PER_TRIANGLE = 12;

endpackage

`default_nettype wire

/* source/triangle_fetch.sv */
// Fetch engine that reads a batch of triangles from vertex memory and hands each to the transform stage.
`default_nettype none

module triangle_fetch
    import gfx_fixed_pkg::*;
    import gfx_mem_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             start,
    input  mem_addr_t        tri_base,
    input  tri_count_t       tri_count,
    vertex_mem_if.requester  mem,
    output fixed_t           tri_vertex [9],
    output color_t           tri_color [3],
    output logic             tri_valid,
    input  logic             tri_stall,
    input  logic             stage_valid,
    output logic             busy
);

    typedef enum logic [2:0] {
        idle,
        read_wait,
        read_release,
        present,
        drain
    } fetch_state_t;

    fetch_state_t state;
    tri_count_t   tri_left;
    logic [3:0]   word_idx;  // word within the triangle.
    logic [3:0]   slot;      // coordinate slot in tri_vertex.
    logic         last_word;

    assign mem.we = 1'b0;
    assign mem.wdata = '0;

    assign slot = 4'(word_idx[3:2]) * 4'd3 + 4'(word_idx[1:0]);
    assign last_word = (word_idx == 4'(WORDS_PER_TRIANGLE - 1));

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= idle;
            tri_left <= '0;
            word_idx <= '0;
            mem.req <= 1'b0;
            mem.addr <= '0;
            tri_valid <= 1'b0;
            busy <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        busy <= 1'b1;
                        tri_left <= tri_count;
                        mem.addr <= tri_base;
                        word_idx <= '0;
                        if (tri_count != '0) begin
                            mem.req <= 1'b1;
                            state <= read_wait;
                        end else begin
                            state <= drain;
                        end
                    end
                end
                read_wait: begin
                    if (mem.ack) begin
                        mem.req <= 1'b0;
                        mem.addr <= mem.addr + 1'b1;
                        state <= read_release;
                    end
                end
                read_release: begin
                    if (!mem.ack) begin
                        if (last_word) begin
                            tri_valid <= 1'b1;
                            state <= present;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            mem.req <= 1'b1;
                            state <= read_wait;
                        end
                    end
                end
                present: begin
                    if (!tri_stall) begin // transfer on this edge.
                        tri_valid <= 1'b0;
                        word_idx <= '0;
                        tri_left <= tri_left - 1'b1;
                        if (tri_left == tri_count_t'(1)) begin
                            state <= drain;
                        end else begin
                            mem.req <= 1'b1;
                            state <= read_wait;
                        end
                    end
                end
                drain: begin
                    if (!stage_valid) begin // last result has left the stage.
                        busy <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == read_wait && mem.ack) begin
            if (word_idx[1:0] == 2'd3) begin
                tri_color[word_idx[3:2]] <= color_t'(mem.rdata[23:0]);
            end else begin
                tri_vertex[slot] <= mem.rdata;
            end
        end
    end

endmodule

`default_nettype wire

/* source/vertex_mem_arbiter.sv */
// Vertex memory shared by the host and the fetch engine, granted round-robin over four-phase handshakes.
`default_nettype none

module vertex_mem_arbiter
    import gfx_mem_pkg::*;
(
    input logic           clock,
    input logic           reset,
    vertex_mem_if.arbiter host,
    vertex_mem_if.arbiter fetch
);

    typedef enum logic [1:0] {
        idle,
        serve_host,
        serve_fetch
    } arb_state_t;

    arb_state_t state;
    logic       last_host; // host took the previous grant.
    logic       grant_host;
    logic       grant_fetch;
    logic       sel_we;
    mem_addr_t  sel_addr;
    mem_word_t  sel_wdata;
    mem_word_t  mem [MEM_DEPTH];

    always_comb begin
        // on a tie the requester not served last wins.
        grant_host = (state == idle) && host.req && (!fetch.req || !last_host);
        grant_fetch = (state == idle) && fetch.req && !grant_host;
        if (grant_host) begin
            sel_we = host.we;
            sel_addr = host.addr;
            sel_wdata = host.wdata;
        end else begin
            sel_we = fetch.we;
            sel_addr = fetch.addr;
            sel_wdata = fetch.wdata;
        end
    end

    // the access itself happens on the grant edge.
    always_ff @(posedge clock) begin
        if ((grant_host || grant_fetch) && sel_we) begin
            mem[sel_addr] <= sel_wdata;
        end
        if (grant_host) begin
            host.rdata <= mem[sel_addr];
        end
        if (grant_fetch) begin
            fetch.rdata <= mem[sel_addr];
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= idle;
            last_host <= 1'b0;
            host.ack <= 1'b0;
            fetch.ack <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (grant_host) begin
                        host.ack <= 1'b1;
                        last_host <= 1'b1;
                        state <= serve_host;
                    end else if (grant_fetch) begin
                        fetch.ack <= 1'b1;
                        last_host <= 1'b0;
                        state <= serve_fetch;
                    end
                end
                serve_host: begin
                    if (!host.req) begin // hold the grant until req falls.
                        host.ack <= 1'b0;
                        state <= idle;
                    end
                end
                serve_fetch: begin
                    if (!fetch.req) begin
                        fetch.ack <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/vertex_mem_if.sv */
// One requester's four-phase req/ack access path to the vertex memory, with requester and arbiter views.
`default_nettype none

interface vertex_mem_if
    import gfx_mem_pkg::*;
();

    logic      req;
    logic      ack;
    logic      we;
    mem_addr_t addr;
    mem_word_t wdata;
    mem_word_t rdata; // valid while ack is high.

    // req rises with we, addr and wdata stable.
    // req drops after ack, and rises again only once ack is low.
    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

/* source/vertex_transform.sv */
// Transform stage that multiplies each triangle vertex by the loaded matrix and maps it to screen space.
`default_nettype none

module vertex_transform
    import gfx_fixed_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       mat_we,
    input  mat_index_t mat_index,
    input  fixed_t     mat_data,
    input  fixed_t     tri_vertex [9],
    input  color_t     tri_color [3],
    input  logic       tri_valid,
    output logic       tri_stall,
    output fixed_t     x_out [3],
    output fixed_t     y_out [3],
    output fixed_t     z_out [3],
    output fixed_t     w_out [3],
    output color_t     color_out [3],
    output logic       out_valid,
    input  logic       out_stall
);

    fixed_t mat [16];       // row-major.
    fixed_t row_sum [3][4]; // vertex, output row.
    fixed_t mapped [3][4];
    logic   take;

    // a full output register that cannot drain blocks the input.
    assign tri_stall = out_valid && out_stall;
    assign take = tri_valid && !tri_stall;

    always_ff @(posedge clock) begin
        if (mat_we) begin
            mat[mat_index] <= mat_data;
        end
    end

    always_comb begin
        fixed_t scale;
        for (int v = 0; v < 3; v++) begin
            for (int r = 0; r < 4; r++) begin
                // the w term is exact, since w = 1.0.
                row_sum[v][r] = fx_mul(mat[4 * r], tri_vertex[3 * v])
                              + fx_mul(mat[4 * r + 1], tri_vertex[3 * v + 1])
                              + fx_mul(mat[4 * r + 2], tri_vertex[3 * v + 2])
                              + mat[4 * r + 3];
                scale = (r % 2 == 0) ? HALF_WIDTH : HALF_HEIGHT; // x, z by width.
                mapped[v][r] = fx_mul(row_sum[v][r], scale) + scale;
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (!out_stall) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            for (int v = 0; v < 3; v++) begin
                x_out[v] <= mapped[v][0];
                y_out[v] <= mapped[v][1];
                z_out[v] <= mapped[v][2];
                w_out[v] <= mapped[v][3];
                color_out[v] <= tri_color[v]; // colours pass straight through.
            end
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
source/gfx_fixed_pkg.sv
source/gfx_mem_pkg.sv
source/vertex_mem_if.sv
source/vertex_mem_arbiter.sv
source/triangle_fetch.sv
source/vertex_transform.sv
source/geometry_top.sv
dv/geometry_checker.sv
dv/geometry_tb.sv
